//--- video_subsys.f
+incdir+verif
hw/video_regs_pkg.sv
hw/raster_pkg.sv
hw/port_decoder.sv
hw/video_ports.sv
hw/raster_timer.sv
hw/layer_scroller.sv
hw/layer_fetch_arbiter.sv
hw/video_subsys.sv
verif/video_subsys_tb.sv

//--- Bender.yml
package:
  name: video_subsys

sources:
  - hw/video_regs_pkg.sv
  - hw/raster_pkg.sv
  - hw/port_decoder.sv
  - hw/video_ports.sv
  - hw/raster_timer.sv
  - hw/layer_scroller.sv
  - hw/layer_fetch_arbiter.sv
  - hw/video_subsys.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/video_subsys_tb.sv

//--- verif/video_subsys_tests.svh
// directed video subsystem tests included inside the testbench top module
`ifndef VIDEO_SUBSYS_TESTS_SVH
`define VIDEO_SUBSYS_TESTS_SVH

task automatic test_reset_values();
    video_regs_pkg::video_regs_t exp_regs;
    exp_regs          = '0;
    exp_regs.vpage    = video_regs_pkg::VPAGE_RST;
    exp_regs.palsel   = video_regs_pkg::PALSEL_RST;
    exp_regs.hint_beg = video_regs_pkg::HINT_BEG_RST;
    @(negedge clk);
    check_eq("regs in reset", regs, exp_regs);
    check_eq("fetch valid in reset", fetch_req.valid, 1'b0);
    check_eq("line_start in reset", line_start, 1'b0);
    check_eq("int_pulse in reset", int_pulse, 1'b0);
    end_test("reset values");
endtask

task automatic test_immediate_writes();
    logic [7:0] d;
    logic [8:0] v;
    d = 8'($random(seed));
    write_port(video_regs_pkg::PORT_BORDER, d);
    settle();
    check_eq("border", regs.border, d);
    // legacy border keeps only the colour bits
    d = 8'($random(seed));
    write_port(video_regs_pkg::PORT_ZBORDER, d);
    settle();
    check_eq("zborder", regs.border, {5'b11110, d[2:0]});
    d = 8'($random(seed));
    write_port(video_regs_pkg::PORT_TSCONF, d);
    settle();
    check_eq("tsconf", regs.tsconf, d);
    d = 8'($random(seed));
    write_port(video_regs_pkg::PORT_TMPAGE, d);
    settle();
    check_eq("tmpage", regs.tmpage, d);
    d = 8'($random(seed));
    write_port(video_regs_pkg::PORT_SGPAGE, d);
    settle();
    check_eq("sgpage", regs.sgpage, d);
    write_offs(video_regs_pkg::PORT_GY_OFFSL, video_regs_pkg::PORT_GY_OFFSH, v);
    settle();
    check_eq("gy_offs", regs.gy_offs, v);
    write_offs(video_regs_pkg::PORT_T0X_OFFSL, video_regs_pkg::PORT_T0X_OFFSH, v);
    settle();
    check_eq("t0x_offs", regs.t0x_offs, v);
    write_offs(video_regs_pkg::PORT_T0Y_OFFSL, video_regs_pkg::PORT_T0Y_OFFSH, v);
    settle();
    check_eq("t0y_offs", regs.t0y_offs, v);
    write_offs(video_regs_pkg::PORT_T1X_OFFSL, video_regs_pkg::PORT_T1X_OFFSH, v);
    settle();
    check_eq("t1x_offs", regs.t1x_offs, v);
    write_offs(video_regs_pkg::PORT_T1Y_OFFSL, video_regs_pkg::PORT_T1Y_OFFSH, v);
    settle();
    check_eq("t1y_offs", regs.t1y_offs, v);
    write_offs(video_regs_pkg::PORT_VINT_BEGL, video_regs_pkg::PORT_VINT_BEGH, v);
    settle();
    check_eq("vint_beg", regs.vint_beg, v);
    end_test("immediate writes");
endtask

task automatic test_line_latched();
    logic [7:0] vc;
    logic [7:0] ps;
    logic [7:0] zp;
    logic [7:0] zp_exp;
    logic [8:0] gx;
    vc     = 8'($random(seed));
    ps     = 8'($random(seed));
    // bit 3 set so the legacy page differs from the reset page
    zp     = 8'($random(seed)) | 8'h08;
    zp_exp = {6'b000001, zp[3], 1'b1};
    // start early in a line so no line start falls between writes
    wait_line_start();
    write_port(video_regs_pkg::PORT_VCONF, vc);
    write_port(video_regs_pkg::PORT_PALSEL, ps);
    write_offs(video_regs_pkg::PORT_GX_OFFSL, video_regs_pkg::PORT_GX_OFFSH, gx);
    settle();
    check_eq("vconf held", regs.vconf, 8'h00);
    check_eq("palsel held", regs.palsel, video_regs_pkg::PALSEL_RST);
    check_eq("gx_offs held", regs.gx_offs, 9'h000);
    write_port(video_regs_pkg::PORT_ZVPAGE, zp);
    settle();
    check_eq("zvpage bypass", regs.vpage, zp_exp);
    wait_line_start();
    @(negedge clk);
    check_eq("vconf latched", regs.vconf, vc);
    check_eq("palsel latched", regs.palsel, ps);
    check_eq("gx_offs latched", regs.gx_offs, gx);
    check_eq("vpage after line", regs.vpage, zp_exp);
    end_test("line latched writes");
endtask

task automatic test_int_position();
    logic [7:0] h;
    logic [8:0] v;
    int         cyc;
    int         n;
    h = 8'd20 + 8'($random(seed) & 63);
    v = 9'd4 + 9'($random(seed) & 15);
    write_port(video_regs_pkg::PORT_HINT_BEG, h);
    write_port(video_regs_pkg::PORT_VINT_BEGL, v[7:0]);
    write_port(video_regs_pkg::PORT_VINT_BEGH, {7'b0, v[8]});
    settle();
    check_eq("hint_beg", regs.hint_beg, h);
    wait_line_start();
    cyc = 0;
    n   = 0;
    while (!int_pulse && n < 2 * FRAME_CYCLES)
    begin
        @(negedge clk);
        n++;
        if (line_start)
            cyc = 0;
        else
            cyc++;
    end
    if (!int_pulse)
        stop_on_timeout("int_pulse");
    else
    begin
        check_eq("int line", line_num, v);
        check_eq("int pixel", cyc, 2 * h);
        @(negedge clk);
        check_eq("int width", int_pulse, 1'b0);
        end_test("interrupt position");
    end
endtask

task automatic test_fetch_rotation();
    logic [8:0] xo [4];
    logic [8:0] yo [4];
    logic [7:0] pg [4];
    logic [8:0] exp_x;
    logic [8:0] exp_y;
    logic [1:0] prev_id;
    int         cyc;
    int         n;
    int         k;
    bit         seen_ls;
    pg[0] = 8'($random(seed));
    pg[1] = 8'($random(seed));
    pg[2] = 8'($random(seed));
    write_offs(video_regs_pkg::PORT_GX_OFFSL, video_regs_pkg::PORT_GX_OFFSH, xo[0]);
    write_offs(video_regs_pkg::PORT_GY_OFFSL, video_regs_pkg::PORT_GY_OFFSH, yo[0]);
    write_offs(video_regs_pkg::PORT_T0X_OFFSL, video_regs_pkg::PORT_T0X_OFFSH, xo[1]);
    write_offs(video_regs_pkg::PORT_T0Y_OFFSL, video_regs_pkg::PORT_T0Y_OFFSH, yo[1]);
    write_offs(video_regs_pkg::PORT_T1X_OFFSL, video_regs_pkg::PORT_T1X_OFFSH, xo[2]);
    write_offs(video_regs_pkg::PORT_T1Y_OFFSL, video_regs_pkg::PORT_T1Y_OFFSH, yo[2]);
    write_port(video_regs_pkg::PORT_VPAGE, pg[0]);
    write_port(video_regs_pkg::PORT_T0GPAGE, pg[1]);
    write_port(video_regs_pkg::PORT_T1GPAGE, pg[2]);
    write_port(video_regs_pkg::PORT_VCONF, 8'h00);
    write_port(video_regs_pkg::PORT_TSCONF, 8'((1 << video_regs_pkg::TSCONF_T0_EN)
                                             | (1 << video_regs_pkg::TSCONF_T1_EN)));
    settle();
    // track the pixel position from a line start seen after the writes
    seen_ls = 1'b0;
    cyc     = 0;
    n       = 0;
    while (!(seen_ls && fetch_req.valid) && n < 2 * FRAME_CYCLES)
    begin
        @(negedge clk);
        n++;
        if (line_start)
        begin
            seen_ls = 1'b1;
            cyc     = 0;
        end
        else
            cyc++;
    end
    if (!(seen_ls && fetch_req.valid))
        stop_on_timeout("an active fetch request");
    else
    begin
        prev_id = 2'd0;
        for (k = 0; k < 16; k++)
        begin
            if (k > 0)
                check_eq("slot order", fetch_req.id, 2'(prev_id + 2'd1));
            check_eq("slot valid", fetch_req.valid, fetch_req.id != 2'd3);
            if (fetch_req.valid)
            begin
                // two cycles of pipeline from raster count to request
                exp_x = 9'(cyc - 2) + xo[fetch_req.id];
                exp_y = 9'(line_num) + yo[fetch_req.id];
                check_eq("fetch x", fetch_req.x, exp_x);
                check_eq("fetch y", fetch_req.y, exp_y);
                check_eq("fetch page", fetch_req.page, pg[fetch_req.id]);
            end
            prev_id = fetch_req.id;
            @(negedge clk);
            cyc++;
        end
        end_test("fetch rotation");
    end
endtask

task automatic test_layer_disable();
    int n;
    int k;
    write_port(video_regs_pkg::PORT_TSCONF, 8'h00);
    settle();
    n = 0;
    while (!fetch_req.valid && n < 2 * FRAME_CYCLES)
    begin
        @(negedge clk);
        n++;
    end
    if (!fetch_req.valid)
        stop_on_timeout("a graphics layer fetch");
    else
    begin
        // only the graphics slot may carry a request
        for (k = 0; k < 32; k++)
        begin
            check_eq("tile slot masked", fetch_req.valid, fetch_req.id == 2'd0);
            @(negedge clk);
        end
        end_test("layer disable");
    end
endtask

`endif

//--- verif/video_subsys_tb.sv
// testbench top for the video subsystem with clock, reset, DUT and the directed test sequence
`timescale 1ns/1ns

module video_subsys_tb;

    localparam int FRAME_CYCLES = raster_pkg::H_TOTAL * raster_pkg::V_TOTAL;

    logic                        clk;
    logic                        rst;
    logic [7:0]                  port_addr;
    logic [7:0]                  port_data;
    logic                        port_wr;
    video_regs_pkg::video_regs_t regs;
    logic                        line_start;
    logic                        int_pulse;
    raster_pkg::layer_fetch_t    fetch_req;

    integer seed = 32'h7368_be9b;
    int     test_checks;
    int     test_errors;
    int     total_checks;
    int     total_errors;
    int     tests_failed;
    // raster line index counted from reset by line_start pulses
    int     line_num;

    video_subsys uut (
        .clk        (clk),
        .rst        (rst),
        .port_addr  (port_addr),
        .port_data  (port_data),
        .port_wr    (port_wr),
        .regs       (regs),
        .line_start (line_start),
        .int_pulse  (int_pulse),
        .fetch_req  (fetch_req)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (rst)
            line_num <= 0;
        else if (line_start)
            line_num <= (line_num == raster_pkg::V_TOTAL - 1) ? 0 : line_num + 1;
    end

    // one-cycle Z80 port write that returns on the edge sampling port_wr
    task automatic write_port(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        port_addr <= addr;
        port_data <= data;
        port_wr   <= 1'b1;
        @(posedge clk);
        port_wr   <= 1'b0;
    endtask

    // random 9-bit value written as low byte then high byte
    task automatic write_offs(input logic [7:0] addr_l, input logic [7:0] addr_h,
                              output logic [8:0] val);
        logic [7:0] lo;
        logic [7:0] hi;
        lo = 8'($random(seed));
        hi = 8'($random(seed));
        write_port(addr_l, lo);
        write_port(addr_h, hi);
        val = {hi[0], lo};
    endtask

    // register output is valid in the cycle after the strobe
    task automatic settle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_eq(input string what, input logic [159:0] got,
                            input logic [159:0] exp);
        test_checks++;
        assert (got === exp)
        else
        begin
            $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s never arrived", what);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic wait_line_start();
        int n;
        n = 0;
        @(negedge clk);
        while (!line_start && n < raster_pkg::H_TOTAL + 8)
        begin
            @(negedge clk);
            n++;
        end
        if (!line_start)
            stop_on_timeout("line_start pulse");
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        if (test_errors != 0)
            tests_failed++;
        test_checks = 0;
        test_errors = 0;
    endtask

    `include "video_subsys_tests.svh"

    initial
    begin
        rst          = 1'b1;
        port_addr    = '0;
        port_data    = '0;
        port_wr      = 1'b0;
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        tests_failed = 0;
        repeat (12) @(posedge clk);
        test_reset_values();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_immediate_writes();
        test_line_latched();
        test_int_position();
        test_fetch_rotation();
        test_layer_disable();
        $display("summary: 6 tests, %0d failed, %0d checks, %0d errors",
                 tests_failed, total_checks, total_errors);
        if (total_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- hw/video_subsys.sv
// video control-port subsystem top: port decode, register bank, raster timer and layer fetch
`timescale 1ns/1ns

module video_subsys (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [7:0]                  port_addr,
    input  logic [7:0]                  port_data,
    input  logic                        port_wr,
    output video_regs_pkg::video_regs_t regs,
    output logic                        line_start,
    output logic                        int_pulse,
    output raster_pkg::layer_fetch_t    fetch_req
);

    video_regs_pkg::port_strobes_t strobes;
    logic [7:0]                    wr_data;
    raster_pkg::coord_t            hcount;
    raster_pkg::coord_t            vcount;
    logic                          active;
    raster_pkg::layer_cfg_t        layer_cfg [raster_pkg::NUM_LAYERS];
    raster_pkg::layer_fetch_t      fetches   [raster_pkg::NUM_LAYERS];

    port_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .port_addr (port_addr),
        .port_data (port_data),
        .port_wr   (port_wr),
        .strobes   (strobes),
        .wr_data   (wr_data)
    );

    video_ports u_ports (
        .clk        (clk),
        .rst        (rst),
        .wr_data    (wr_data),
        .strobes    (strobes),
        .line_start (line_start),
        .regs       (regs)
    );

    raster_timer u_timer (
        .clk        (clk),
        .rst        (rst),
        .hint_beg   (regs.hint_beg),
        .vint_beg   (regs.vint_beg),
        .hcount     (hcount),
        .vcount     (vcount),
        .active     (active),
        .line_start (line_start),
        .int_pulse  (int_pulse)
    );

    // layer 0 graphics, layers 1 and 2 tiles
    assign layer_cfg[0] = '{x_offs: regs.gx_offs,  y_offs: regs.gy_offs,  page: regs.vpage};
    assign layer_cfg[1] = '{x_offs: regs.t0x_offs, y_offs: regs.t0y_offs, page: regs.t0gpage};
    assign layer_cfg[2] = '{x_offs: regs.t1x_offs, y_offs: regs.t1y_offs, page: regs.t1gpage};

    for (genvar i = 0; i < raster_pkg::NUM_LAYERS; i++)
    begin : g_layer
        layer_scroller #(
            .LAYER_ID (i)
        ) u_scroller (
            .clk    (clk),
            .rst    (rst),
            .cfg    (layer_cfg[i]),
            .hcount (hcount),
            .vcount (vcount),
            .active (active),
            .fetch  (fetches[i])
        );
    end

    layer_fetch_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .fetches   (fetches),
        .vconf     (regs.vconf),
        .tsconf    (regs.tsconf),
        .fetch_req (fetch_req)
    );

endmodule

//--- hw/layer_fetch_arbiter.sv
// four-slot fetch rotation over the layer scrollers, masking disabled layers
`timescale 1ns/1ns

module layer_fetch_arbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  raster_pkg::layer_fetch_t fetches [raster_pkg::NUM_LAYERS],
    input  logic [7:0]               vconf,
    input  logic [7:0]               tsconf,
    output raster_pkg::layer_fetch_t fetch_req
);

    // 2-bit counter wraps after slot 3
    logic [1:0]                      slot;
    logic [raster_pkg::NUM_LAYERS-1:0] layer_en;
    raster_pkg::layer_fetch_t        sel;

    assign layer_en = {tsconf[video_regs_pkg::TSCONF_T1_EN],
                       tsconf[video_regs_pkg::TSCONF_T0_EN],
                       ~vconf[video_regs_pkg::VCONF_GFX_OFF]};

    always_comb
    begin
        sel    = '0;
        sel.id = slot;
        // slots past the last layer stay idle
        if (slot < raster_pkg::NUM_LAYERS)
        begin
            sel       = fetches[slot];
            sel.valid = fetches[slot].valid & layer_en[slot];
        end
    end

    always_ff @(posedge clk)
    begin
        fetch_req.id   <= sel.id;
        fetch_req.page <= sel.page;
        fetch_req.x    <= sel.x;
        fetch_req.y    <= sel.y;
        if (rst)
        begin
            slot            <= '0;
            fetch_req.valid <= 1'b0;
        end
        else
        begin
            slot            <= slot + 1'b1;
            fetch_req.valid <= sel.valid;
        end
    end

endmodule

//--- hw/layer_scroller.sv
// per-layer scroll adder: raster position plus layer offsets, tagged with page and layer id
`timescale 1ns/1ns

module layer_scroller #(
    parameter int LAYER_ID = 0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  raster_pkg::layer_cfg_t   cfg,
    input  raster_pkg::coord_t       hcount,
    input  raster_pkg::coord_t       vcount,
    input  logic                     active,
    output raster_pkg::layer_fetch_t fetch
);

    always_ff @(posedge clk)
    begin
        // 9-bit sums wrap modulo 512
        fetch.x    <= hcount + cfg.x_offs;
        fetch.y    <= vcount + cfg.y_offs;
        fetch.page <= cfg.page;
        fetch.id   <= 2'(LAYER_ID);
        if (rst)
            fetch.valid <= 1'b0;
        else
            fetch.valid <= active;
    end

endmodule

//--- hw/raster_timer.sv
// raster position counters with line start and programmable frame interrupt pulses
`timescale 1ns/1ns

module raster_timer (
    input  logic               clk,
    input  logic               rst,
    input  logic [7:0]         hint_beg,
    input  raster_pkg::coord_t vint_beg,
    output raster_pkg::coord_t hcount,
    output raster_pkg::coord_t vcount,
    output logic               active,
    output logic               line_start,
    output logic               int_pulse
);

    raster_pkg::coord_t h_nx;
    raster_pkg::coord_t v_nx;
    logic               h_wrap;

    assign h_wrap = (hcount == raster_pkg::coord_t'(raster_pkg::H_TOTAL - 1));

    always_comb
    begin
        h_nx = h_wrap ? '0 : hcount + 1'b1;
        v_nx = vcount;
        if (h_wrap)
        begin
            if (vcount == raster_pkg::coord_t'(raster_pkg::V_TOTAL - 1))
                v_nx = '0;
            else
                v_nx = vcount + 1'b1;
        end
    end

    // flags decoded from the next position so they line up with the counts
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hcount     <= '0;
            vcount     <= '0;
            active     <= 1'b0;
            line_start <= 1'b0;
            int_pulse  <= 1'b0;
        end
        else
        begin
            hcount     <= h_nx;
            vcount     <= v_nx;
            active     <= (h_nx >= raster_pkg::H_ACTIVE_BEG)
                       && (h_nx <  raster_pkg::H_ACTIVE_END)
                       && (v_nx >= raster_pkg::V_ACTIVE_BEG)
                       && (v_nx <  raster_pkg::V_ACTIVE_END);
            line_start <= h_wrap;
            // hint_beg counts in units of two pixel clocks
            int_pulse  <= (h_nx == {hint_beg, 1'b0}) && (v_nx == vint_beg);
        end
    end

endmodule

//--- hw/video_ports.sv
// video register bank: immediate registers plus line-latched shadows, fed by the port decoder
`timescale 1ns/1ns

module video_ports (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [7:0]                    wr_data,
    input  video_regs_pkg::port_strobes_t strobes,
    input  logic                          line_start,
    output video_regs_pkg::video_regs_t   regs
);

    // shadow copies, moved to the outputs at line start
    logic [7:0] vpage_sh;
    logic [7:0] vconf_sh;
    logic [7:0] palsel_sh;
    logic [8:0] gx_offs_sh;

    logic [7:0] vpage_nx;
    logic [7:0] vconf_nx;
    logic [7:0] palsel_nx;
    logic [8:0] gx_offs_nx;

    // next shadow values, so a write in the line start cycle is not lost
    always_comb
    begin
        vpage_nx   = vpage_sh;
        vconf_nx   = vconf_sh;
        palsel_nx  = palsel_sh;
        gx_offs_nx = gx_offs_sh;
        // legacy page form 0000_01x1
        if (strobes.zvpage)
            vpage_nx = {6'b000001, wr_data[3], 1'b1};
        if (strobes.vpage)
            vpage_nx = wr_data;
        if (strobes.vconf)
            vconf_nx = wr_data;
        if (strobes.palsel)
            palsel_nx = wr_data;
        if (strobes.gx_offsl)
            gx_offs_nx[7:0] = wr_data;
        if (strobes.gx_offsh)
            gx_offs_nx[8] = wr_data[0];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            regs        <= '0;
            regs.vpage  <= video_regs_pkg::VPAGE_RST;
            regs.palsel <= video_regs_pkg::PALSEL_RST;
            regs.hint_beg <= video_regs_pkg::HINT_BEG_RST;
            vpage_sh    <= video_regs_pkg::VPAGE_RST;
            vconf_sh    <= '0;
            palsel_sh   <= video_regs_pkg::PALSEL_RST;
            gx_offs_sh  <= '0;
        end
        else
        begin
            // immediate group
            if (strobes.zborder)   regs.border         <= {5'b11110, wr_data[2:0]};
            if (strobes.border)    regs.border         <= wr_data;
            if (strobes.gy_offsl)  regs.gy_offs[7:0]   <= wr_data;
            if (strobes.gy_offsh)  regs.gy_offs[8]     <= wr_data[0];
            if (strobes.t0x_offsl) regs.t0x_offs[7:0]  <= wr_data;
            if (strobes.t0x_offsh) regs.t0x_offs[8]    <= wr_data[0];
            if (strobes.t0y_offsl) regs.t0y_offs[7:0]  <= wr_data;
            if (strobes.t0y_offsh) regs.t0y_offs[8]    <= wr_data[0];
            if (strobes.t1x_offsl) regs.t1x_offs[7:0]  <= wr_data;
            if (strobes.t1x_offsh) regs.t1x_offs[8]    <= wr_data[0];
            if (strobes.t1y_offsl) regs.t1y_offs[7:0]  <= wr_data;
            if (strobes.t1y_offsh) regs.t1y_offs[8]    <= wr_data[0];
            if (strobes.tsconf)    regs.tsconf         <= wr_data;
            if (strobes.tmpage)    regs.tmpage         <= wr_data;
            if (strobes.t0gpage)   regs.t0gpage        <= wr_data;
            if (strobes.t1gpage)   regs.t1gpage        <= wr_data;
            if (strobes.sgpage)    regs.sgpage         <= wr_data;
            if (strobes.hint_beg)  regs.hint_beg       <= wr_data;
            if (strobes.vint_begl) regs.vint_beg[7:0]  <= wr_data;
            if (strobes.vint_begh) regs.vint_beg[8]    <= wr_data[0];

            vpage_sh   <= vpage_nx;
            vconf_sh   <= vconf_nx;
            palsel_sh  <= palsel_nx;
            gx_offs_sh <= gx_offs_nx;

            // line-latched group
            if (line_start)
            begin
                regs.vconf   <= vconf_nx;
                regs.palsel  <= palsel_nx;
                regs.gx_offs <= gx_offs_nx;
            end
            // legacy page write bypasses the line latch
            if (line_start || strobes.zvpage)
                regs.vpage <= vpage_nx;
        end
    end

endmodule

//--- hw/port_decoder.sv
// decodes registered Z80 port writes into one-cycle register strobes for the video port bank
`timescale 1ns/1ns

module port_decoder (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [7:0]                   port_addr,
    input  logic [7:0]                   port_data,
    input  logic                         port_wr,
    output video_regs_pkg::port_strobes_t strobes,
    output logic [7:0]                   wr_data
);

    logic [7:0] addr_q;
    logic       wr_q;

    // capture the Z80 write bus
    always_ff @(posedge clk)
    begin
        addr_q  <= port_addr;
        wr_data <= port_data;
        if (rst)
            wr_q <= 1'b0;
        else
            wr_q <= port_wr;
    end

    always_comb
    begin
        strobes = '0;
        if (wr_q)
        begin
            case (addr_q)
                video_regs_pkg::PORT_ZBORDER:   strobes.zborder   = 1'b1;
                video_regs_pkg::PORT_BORDER:    strobes.border    = 1'b1;
                video_regs_pkg::PORT_ZVPAGE:    strobes.zvpage    = 1'b1;
                video_regs_pkg::PORT_VPAGE:     strobes.vpage     = 1'b1;
                video_regs_pkg::PORT_VCONF:     strobes.vconf     = 1'b1;
                video_regs_pkg::PORT_GX_OFFSL:  strobes.gx_offsl  = 1'b1;
                video_regs_pkg::PORT_GX_OFFSH:  strobes.gx_offsh  = 1'b1;
                video_regs_pkg::PORT_GY_OFFSL:  strobes.gy_offsl  = 1'b1;
                video_regs_pkg::PORT_GY_OFFSH:  strobes.gy_offsh  = 1'b1;
                video_regs_pkg::PORT_T0X_OFFSL: strobes.t0x_offsl = 1'b1;
                video_regs_pkg::PORT_T0X_OFFSH: strobes.t0x_offsh = 1'b1;
                video_regs_pkg::PORT_T0Y_OFFSL: strobes.t0y_offsl = 1'b1;
                video_regs_pkg::PORT_T0Y_OFFSH: strobes.t0y_offsh = 1'b1;
                video_regs_pkg::PORT_T1X_OFFSL: strobes.t1x_offsl = 1'b1;
                video_regs_pkg::PORT_T1X_OFFSH: strobes.t1x_offsh = 1'b1;
                video_regs_pkg::PORT_T1Y_OFFSL: strobes.t1y_offsl = 1'b1;
                video_regs_pkg::PORT_T1Y_OFFSH: strobes.t1y_offsh = 1'b1;
                video_regs_pkg::PORT_TSCONF:    strobes.tsconf    = 1'b1;
                video_regs_pkg::PORT_PALSEL:    strobes.palsel    = 1'b1;
                video_regs_pkg::PORT_TMPAGE:    strobes.tmpage    = 1'b1;
                video_regs_pkg::PORT_T0GPAGE:   strobes.t0gpage   = 1'b1;
                video_regs_pkg::PORT_T1GPAGE:   strobes.t1gpage   = 1'b1;
                video_regs_pkg::PORT_SGPAGE:    strobes.sgpage    = 1'b1;
                video_regs_pkg::PORT_HINT_BEG:  strobes.hint_beg  = 1'b1;
                video_regs_pkg::PORT_VINT_BEGL: strobes.vint_begl = 1'b1;
                video_regs_pkg::PORT_VINT_BEGH: strobes.vint_begh = 1'b1;
                // unmapped ports are ignored
                default:                        strobes           = '0;
            endcase
        end
    end

endmodule

//--- hw/raster_pkg.sv
// raster geometry and layer fetch types shared by the timer, scrollers and arbiter
package raster_pkg;

    // pixel clocks per line and lines per frame
    localparam int H_TOTAL = 448;
    localparam int V_TOTAL = 320;

    // visible window, end is exclusive
    localparam int H_ACTIVE_BEG = 104;
    localparam int H_ACTIVE_END = 424;
    localparam int V_ACTIVE_BEG = 44;
    localparam int V_ACTIVE_END = 284;

    localparam int NUM_LAYERS = 3;

    typedef logic [8:0] coord_t;

    typedef struct packed {
        coord_t     x_offs;
        coord_t     y_offs;
        logic [7:0] page;
    } layer_cfg_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] id;
        logic [7:0] page;
        coord_t     x;
        coord_t     y;
    } layer_fetch_t;

endpackage

//--- hw/video_regs_pkg.sv
// video register map: port addresses, reset defaults and register structs for decoder and bank
package video_regs_pkg;

    // port addresses, low byte of the Z80 port
    localparam logic [7:0] PORT_VCONF     = 8'h00;
    localparam logic [7:0] PORT_VPAGE     = 8'h01;
    localparam logic [7:0] PORT_GX_OFFSL  = 8'h02;
    localparam logic [7:0] PORT_GX_OFFSH  = 8'h03;
    localparam logic [7:0] PORT_GY_OFFSL  = 8'h04;
    localparam logic [7:0] PORT_GY_OFFSH  = 8'h05;
    localparam logic [7:0] PORT_TSCONF    = 8'h06;
    localparam logic [7:0] PORT_PALSEL    = 8'h07;
    localparam logic [7:0] PORT_BORDER    = 8'h0F;
    localparam logic [7:0] PORT_TMPAGE    = 8'h15;
    localparam logic [7:0] PORT_T0GPAGE   = 8'h16;
    localparam logic [7:0] PORT_T1GPAGE   = 8'h17;
    localparam logic [7:0] PORT_SGPAGE    = 8'h19;
    localparam logic [7:0] PORT_HINT_BEG  = 8'h22;
    localparam logic [7:0] PORT_VINT_BEGL = 8'h23;
    localparam logic [7:0] PORT_VINT_BEGH = 8'h24;
    localparam logic [7:0] PORT_T0X_OFFSL = 8'h40;
    localparam logic [7:0] PORT_T0X_OFFSH = 8'h41;
    localparam logic [7:0] PORT_T0Y_OFFSL = 8'h42;
    localparam logic [7:0] PORT_T0Y_OFFSH = 8'h43;
    localparam logic [7:0] PORT_T1X_OFFSL = 8'h44;
    localparam logic [7:0] PORT_T1X_OFFSH = 8'h45;
    localparam logic [7:0] PORT_T1Y_OFFSL = 8'h46;
    localparam logic [7:0] PORT_T1Y_OFFSH = 8'h47;
    // legacy short forms
    localparam logic [7:0] PORT_ZBORDER   = 8'hFE;
    localparam logic [7:0] PORT_ZVPAGE    = 8'hFD;

    // non-zero reset defaults
    localparam logic [7:0] VPAGE_RST    = 8'h05;
    localparam logic [7:0] PALSEL_RST   = 8'h0F;
    localparam logic [7:0] HINT_BEG_RST = 8'd2;

    // layer enable bits
    localparam int TSCONF_T0_EN  = 5;
    localparam int TSCONF_T1_EN  = 6;
    localparam int VCONF_GFX_OFF = 5;

    typedef struct packed {
        logic zborder;
        logic border;
        logic zvpage;
        logic vpage;
        logic vconf;
        logic gx_offsl;
        logic gx_offsh;
        logic gy_offsl;
        logic gy_offsh;
        logic t0x_offsl;
        logic t0x_offsh;
        logic t0y_offsl;
        logic t0y_offsh;
        logic t1x_offsl;
        logic t1x_offsh;
        logic t1y_offsl;
        logic t1y_offsh;
        logic tsconf;
        logic palsel;
        logic tmpage;
        logic t0gpage;
        logic t1gpage;
        logic sgpage;
        logic hint_beg;
        logic vint_begl;
        logic vint_begh;
    } port_strobes_t;

    typedef struct packed {
        logic [7:0] border;
        logic [7:0] vpage;
        logic [7:0] vconf;
        logic [7:0] palsel;
        logic [7:0] hint_beg;
        logic [7:0] tsconf;
        logic [7:0] tmpage;
        logic [7:0] t0gpage;
        logic [7:0] t1gpage;
        logic [7:0] sgpage;
        logic [8:0] gx_offs;
        logic [8:0] gy_offs;
        logic [8:0] t0x_offs;
        logic [8:0] t0y_offs;
        logic [8:0] t1x_offs;
        logic [8:0] t1y_offs;
        logic [8:0] vint_beg;
    } video_regs_t;

endpackage
